// ==== Bender.yml ====
package:
  name: fpu_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/fpu_data_pkg.sv
      - hw/fpu_op_pkg.sv
      - hw/operand_bypass.sv
      - hw/fpu_op_decode.sv
      - hw/fpu_simd_exec.sv
      - hw/fpu_compare.sv
      - hw/fpu_excpt_report.sv
      - hw/fpu_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/fpu_unit_tb.sv

// ==== filelist.f ====
+incdir+include
hw/fpu_data_pkg.sv
hw/fpu_op_pkg.sv
hw/operand_bypass.sv
hw/fpu_op_decode.sv
hw/fpu_simd_exec.sv
hw/fpu_compare.sv
hw/fpu_excpt_report.sv
hw/fpu_unit.sv
sim/fpu_unit_tb.sv

// ==== hw/fpu_compare.sv ====
// compare lane: one double or two singles, condition flags and invalid raise
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_compare (
  input  logic                    clk,
  input  logic                    rst,
  input  fpu_op_pkg::fpu_ctrl_t   ctrl,
  input  fpu_data_pkg::fpu_word_u opnd_a,
  input  fpu_data_pkg::fpu_word_u opnd_b,
  output fpu_data_pkg::cmp_pair_t flags,
  output logic [`FPU_FLAG_W-1:0]  raise,
  output logic                    valid
);

  // returns {nan, signaling}
  function automatic logic [1:0] nan_d(input fpu_data_pkg::fp_double_t d);
    logic nan;
    nan = (d.exp == '1) && (d.frac != '0);
    return {nan, nan & ~d.frac[51]};
  endfunction

  function automatic logic [1:0] nan_s(input fpu_data_pkg::fp_single_t s);
    logic nan;
    nan = (s.exp == '1) && (s.frac != '0);
    return {nan, nan & ~s.frac[22]};
  endfunction

  // sign-magnitude ordering, both zeros equal
  function automatic fpu_data_pkg::cmp_flags_t cmp_lane(
    input logic sa, input logic [62:0] ma,
    input logic sb, input logic [62:0] mb,
    input logic unord);
    fpu_data_pkg::cmp_flags_t f;
    logic a_lt;
    f = '0;
    a_lt = (ma < mb) ^ sa;
    if (unord) begin
      f.unord = 1'b1;
    end else if (ma == '0 && mb == '0) begin
      f.equal = 1'b1;
    end else if (sa != sb) begin
      f.less    = sa;
      f.greater = sb;
    end else if (ma == mb) begin
      f.equal = 1'b1;
    end else begin
      f.less    = a_lt;
      f.greater = ~a_lt;
    end
    return f;
  endfunction

  logic [1:0] na_d, nb_d, na_hi, nb_hi, na_lo, nb_lo;
  fpu_data_pkg::cmp_flags_t f_d, f_hi, f_lo;
  fpu_data_pkg::cmp_pair_t  flags_c;
  logic [`FPU_FLAG_W-1:0]   raise_c;
  logic                     any_nan, any_snan, lane_hit;

  assign na_d  = nan_d(opnd_a.dbl);
  assign nb_d  = nan_d(opnd_b.dbl);
  assign na_hi = nan_s(opnd_a.ps.hi);
  assign nb_hi = nan_s(opnd_b.ps.hi);
  assign na_lo = nan_s(opnd_a.ps.lo);
  assign nb_lo = nan_s(opnd_b.ps.lo);

  assign f_d = cmp_lane(opnd_a.dbl.sign, {opnd_a.dbl.exp, opnd_a.dbl.frac},
                        opnd_b.dbl.sign, {opnd_b.dbl.exp, opnd_b.dbl.frac},
                        na_d[1] | nb_d[1]);
  assign f_hi = cmp_lane(opnd_a.ps.hi.sign, 63'({opnd_a.ps.hi.exp, opnd_a.ps.hi.frac}),
                         opnd_b.ps.hi.sign, 63'({opnd_b.ps.hi.exp, opnd_b.ps.hi.frac}),
                         na_hi[1] | nb_hi[1]);
  assign f_lo = cmp_lane(opnd_a.ps.lo.sign, 63'({opnd_a.ps.lo.exp, opnd_a.ps.lo.frac}),
                         opnd_b.ps.lo.sign, 63'({opnd_b.ps.lo.exp, opnd_b.ps.lo.frac}),
                         na_lo[1] | nb_lo[1]);

  assign lane_hit = ctrl.valid && (ctrl.lane == fpu_op_pkg::LANE_CMP);

  always_comb begin
    if (ctrl.paired) begin
      flags_c  = {f_hi, f_lo};
      any_nan  = na_hi[1] | nb_hi[1] | na_lo[1] | nb_lo[1];
      any_snan = na_hi[0] | nb_hi[0] | na_lo[0] | nb_lo[0];
    end else begin
      flags_c  = {4'b0000, f_d};
      any_nan  = na_d[1] | nb_d[1];
      any_snan = na_d[0] | nb_d[0];
    end
    raise_c    = '0;
    // invalid sits in bit 0
    raise_c[0] = any_snan | (ctrl.ordered & any_nan);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      raise <= '0;
    end else begin
      valid <= lane_hit;
      raise <= lane_hit ? raise_c : '0;
    end
  end

  // flags only meaningful for a compare, zero otherwise
  always_ff @(posedge clk) begin
    flags <= lane_hit ? flags_c : '0;
  end

endmodule

`default_nettype wire

// ==== hw/fpu_data_pkg.sv ====
// data-word types of the fpu unit: float views, compare flags and the result bundle
`default_nettype none

package fpu_data_pkg;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp_single_t;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fp_double_t;

  typedef struct packed {
    fp_single_t hi;
    fp_single_t lo;
  } fp_pair_t;

  // one 64-bit register word, seen as a double or as two singles
  typedef union packed {
    fp_double_t dbl;
    fp_pair_t   ps;
  } fpu_word_u;

  typedef struct packed {
    logic unord;
    logic less;
    logic equal;
    logic greater;
  } cmp_flags_t;

  // double compare uses lo only
  typedef struct packed {
    cmp_flags_t hi;
    cmp_flags_t lo;
  } cmp_pair_t;

  typedef struct packed {
    logic      valid;
    fpu_word_u data;
    cmp_pair_t cmp;
  } fpu_result_t;

endpackage

`default_nettype wire

// ==== hw/fpu_excpt_report.sv ====
// masks raised ieee flags with the enables and encodes the reported exception
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_excpt_report (
  input  logic [`FPU_FLAG_W-1:0] raise,
  input  logic [`FPU_FLAG_W-1:0] enables,
  input  logic                   valid,
  output logic                   excpt_en,
  output logic [`FPU_EXC_W-1:0]  excpt_code
);

  logic [`FPU_FLAG_W-1:0] masked;

  assign masked   = raise & enables;
  assign excpt_en = valid & (|masked);

  // lowest surviving flag wins, code is its index plus one
  always_comb begin
    excpt_code = '0;
    for (int i = `FPU_FLAG_W - 1; i >= 0; i--) begin
      if (masked[i]) begin
        excpt_code = `FPU_EXC_W'(i + 1);
      end
    end
  end

  a_code_nonzero: assert final (!excpt_en || excpt_code != '0);

endmodule

`default_nettype wire

// ==== hw/fpu_op_decode.sv ====
// issue stage that registers the operands and decodes the opcode into the control struct
`timescale 1ns/1ps
`default_nettype none

module fpu_op_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue_en,
  input  fpu_op_pkg::fpu_opcode_e opcode,
  input  fpu_data_pkg::fpu_word_u opnd_a_in,
  input  fpu_data_pkg::fpu_word_u opnd_b_in,
  output fpu_op_pkg::fpu_ctrl_t   ctrl,
  output fpu_data_pkg::fpu_word_u opnd_a,
  output fpu_data_pkg::fpu_word_u opnd_b
);

  fpu_op_pkg::fpu_ctrl_t dec;

  always_comb begin
    dec = '0;
    case (opcode)
      fpu_op_pkg::OP_AND, fpu_op_pkg::OP_OR,
      fpu_op_pkg::OP_XOR, fpu_op_pkg::OP_ANDN: begin
        dec.lane  = fpu_op_pkg::LANE_SIMD;
        dec.sub   = opcode[1:0];
        dec.legal = 1'b1;
      end
      fpu_op_pkg::OP_SWAP, fpu_op_pkg::OP_DUPL, fpu_op_pkg::OP_MERGE: begin
        dec.lane   = fpu_op_pkg::LANE_SIMD;
        dec.sub    = opcode[1:0];
        dec.paired = 1'b1;
        dec.legal  = 1'b1;
      end
      fpu_op_pkg::OP_CMPD, fpu_op_pkg::OP_CMPDO,
      fpu_op_pkg::OP_CMPS, fpu_op_pkg::OP_CMPSO: begin
        dec.lane    = fpu_op_pkg::LANE_CMP;
        dec.sub     = opcode[1:0];
        dec.paired  = opcode[1];
        dec.ordered = opcode[0];
        dec.legal   = 1'b1;
      end
      default: begin
        // unknown opcode stays lane none and not legal
        dec.lane = fpu_op_pkg::LANE_NONE;
      end
    endcase
    dec.valid = issue_en & dec.legal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      ctrl <= dec;
    end
  end

  // operand payload registers
  always_ff @(posedge clk) begin
    opnd_a <= opnd_a_in;
    opnd_b <= opnd_b_in;
  end

  // a live stage 1 always targets a real lane
  a_valid_lane: assert property (@(posedge clk) disable iff (rst)
    ctrl.valid |-> (ctrl.lane != fpu_op_pkg::LANE_NONE));

endmodule

`default_nettype wire

// ==== hw/fpu_op_pkg.sv ====
// opcode, operand-source and decoded-control types shared by decode and execution
`default_nettype none

package fpu_op_pkg;

  // low two bits carry the sub-operation
  // for compares bit 1 selects paired singles and bit 0 ordered
  typedef enum logic [7:0] {
    OP_AND   = 8'h10,
    OP_OR    = 8'h11,
    OP_XOR   = 8'h12,
    OP_ANDN  = 8'h13,
    OP_SWAP  = 8'h20,
    OP_DUPL  = 8'h21,
    OP_MERGE = 8'h22,
    OP_CMPD  = 8'h30,
    OP_CMPDO = 8'h31,
    OP_CMPS  = 8'h32,
    OP_CMPSO = 8'h33
  } fpu_opcode_e;

  typedef enum logic [1:0] {
    SRC_RF       = 2'd0,
    SRC_BUS_NOW  = 2'd1,
    SRC_BUS_PREV = 2'd2
  } opnd_kind_e;

  typedef struct packed {
    opnd_kind_e  kind;
    logic [1:0]  idx;
  } opnd_src_t;

  typedef enum logic [1:0] {
    LANE_NONE = 2'd0,
    LANE_SIMD = 2'd1,
    LANE_CMP  = 2'd2
  } fpu_lane_e;

  // paired also tells permute (set) from logic (clear) in the simd lane
  typedef struct packed {
    logic       valid;
    fpu_lane_e  lane;
    logic [1:0] sub;
    logic       paired;
    logic       ordered;
    logic       legal;
  } fpu_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/fpu_simd_exec.sv ====
// simd lane: 64-bit logic ops and single-precision half permutes, one register stage
`timescale 1ns/1ps
`default_nettype none

module fpu_simd_exec (
  input  logic                    clk,
  input  logic                    rst,
  input  fpu_op_pkg::fpu_ctrl_t   ctrl,
  input  fpu_data_pkg::fpu_word_u opnd_a,
  input  fpu_data_pkg::fpu_word_u opnd_b,
  output fpu_data_pkg::fpu_word_u data,
  output logic                    valid
);

  fpu_data_pkg::fpu_word_u res_c;
  logic                    lane_hit;

  assign lane_hit = ctrl.valid && (ctrl.lane == fpu_op_pkg::LANE_SIMD);

  always_comb begin
    res_c = opnd_a;
    if (ctrl.paired) begin
      // permutes on the paired-single view
      case (ctrl.sub)
        2'd0: begin
          res_c.ps.hi = opnd_a.ps.lo;
          res_c.ps.lo = opnd_a.ps.hi;
        end
        2'd1: begin
          res_c.ps.hi = opnd_a.ps.lo;
          res_c.ps.lo = opnd_a.ps.lo;
        end
        2'd2: begin
          res_c.ps.hi = opnd_b.ps.hi;
          res_c.ps.lo = opnd_a.ps.lo;
        end
        default: begin
          res_c = opnd_a;
        end
      endcase
    end else begin
      case (ctrl.sub)
        2'd0:    res_c = opnd_a & opnd_b;
        2'd1:    res_c = opnd_a | opnd_b;
        2'd2:    res_c = opnd_a ^ opnd_b;
        default: res_c = opnd_a & ~opnd_b;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= lane_hit;
    end
  end

  always_ff @(posedge clk) begin
    data <= res_c;
  end

endmodule

`default_nettype wire

// ==== hw/fpu_unit.sv ====
// fpu unit top: operand bypass, decode, simd and compare lanes, exception report
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      issue_en,
  input  fpu_op_pkg::fpu_opcode_e   opcode,
  input  fpu_op_pkg::opnd_src_t     src_a,
  input  fpu_op_pkg::opnd_src_t     src_b,
  input  fpu_data_pkg::fpu_word_u   rf_a,
  input  fpu_data_pkg::fpu_word_u   rf_b,
  input  fpu_data_pkg::fpu_word_u   fwd_bus [`FPU_FWD_BUSES],
  input  logic [31:0]               fpcsr,
  output fpu_data_pkg::fpu_result_t res,
  output logic                      excpt_en,
  output logic [`FPU_EXC_W-1:0]     excpt_code
);

  fpu_data_pkg::fpu_word_u byp_a, byp_b;
  fpu_data_pkg::fpu_word_u s1_a, s1_b;
  fpu_op_pkg::fpu_ctrl_t   s1_ctrl;
  fpu_data_pkg::fpu_word_u simd_data;
  logic                    simd_valid;
  fpu_data_pkg::cmp_pair_t cmp_flags;
  logic [`FPU_FLAG_W-1:0]  cmp_raise;
  logic                    cmp_valid;

  operand_bypass u_byp_a (
    .clk    (clk),
    .rst    (rst),
    .src    (src_a),
    .rf_val (rf_a),
    .fwd_bus(fwd_bus),
    .opnd   (byp_a)
  );

  operand_bypass u_byp_b (
    .clk    (clk),
    .rst    (rst),
    .src    (src_b),
    .rf_val (rf_b),
    .fwd_bus(fwd_bus),
    .opnd   (byp_b)
  );

  fpu_op_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .issue_en (issue_en),
    .opcode   (opcode),
    .opnd_a_in(byp_a),
    .opnd_b_in(byp_b),
    .ctrl     (s1_ctrl),
    .opnd_a   (s1_a),
    .opnd_b   (s1_b)
  );

  fpu_simd_exec u_simd (
    .clk   (clk),
    .rst   (rst),
    .ctrl  (s1_ctrl),
    .opnd_a(s1_a),
    .opnd_b(s1_b),
    .data  (simd_data),
    .valid (simd_valid)
  );

  fpu_compare u_cmp (
    .clk   (clk),
    .rst   (rst),
    .ctrl  (s1_ctrl),
    .opnd_a(s1_a),
    .opnd_b(s1_b),
    .flags (cmp_flags),
    .raise (cmp_raise),
    .valid (cmp_valid)
  );

  // fpcsr[4:0] holds the exception enables
  fpu_excpt_report u_excpt (
    .raise     (cmp_raise),
    .enables   (fpcsr[`FPU_FLAG_W-1:0]),
    .valid     (cmp_valid),
    .excpt_en  (excpt_en),
    .excpt_code(excpt_code)
  );

  // compare results carry a zero data word
  assign res.valid = simd_valid | cmp_valid;
  assign res.data  = simd_valid ? simd_data : '0;
  assign res.cmp   = cmp_flags;

endmodule

`default_nettype wire

// ==== hw/operand_bypass.sv ====
// operand source select: register file, forwarding bus now, or bus value one cycle old
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module operand_bypass (
  input  logic                  clk,
  input  logic                  rst,
  input  fpu_op_pkg::opnd_src_t src,
  input  fpu_data_pkg::fpu_word_u rf_val,
  input  fpu_data_pkg::fpu_word_u fwd_bus [`FPU_FWD_BUSES],
  output fpu_data_pkg::fpu_word_u opnd
);

  // bus values as seen at the previous edge
  fpu_data_pkg::fpu_word_u fwd_prev [`FPU_FWD_BUSES];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FPU_FWD_BUSES; i++) begin
        fwd_prev[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `FPU_FWD_BUSES; i++) begin
        fwd_prev[i] <= fwd_bus[i];
      end
    end
  end

  always_comb begin
    case (src.kind)
      fpu_op_pkg::SRC_BUS_NOW: begin
        opnd = fwd_bus[src.idx];
      end
      fpu_op_pkg::SRC_BUS_PREV: begin
        opnd = fwd_prev[src.idx];
      end
      default: begin
        opnd = rf_val;
      end
    endcase
  end

  // bus index must name an existing bus
  a_bus_idx: assert property (@(posedge clk) disable iff (rst)
    (src.kind == fpu_op_pkg::SRC_BUS_NOW || src.kind == fpu_op_pkg::SRC_BUS_PREV)
      |-> (int'(src.idx) < `FPU_FWD_BUSES));

endmodule

`default_nettype wire

// ==== include/fpu_cfg.svh ====
// fpu sizing macros, included by every RTL and testbench file that needs them
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// operand and result word width
`define FPU_DATA_W 64

// forwarding buses seen by each operand bypass
`define FPU_FWD_BUSES 4

// ieee flags, bit 0 is invalid
// then divide, overflow, underflow, inexact going up
`define FPU_FLAG_W 5

// exception code: lowest raised flag index plus one, zero means none
`define FPU_EXC_W 3

`endif

// ==== sim/fpu_unit_tb.sv ====
// directed testbench for fpu_unit that runs from filelist.f with fpu_unit_tb as top
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_unit_tb;

  localparam int CLK_NS = 10;
  localparam int RESET_CYC = 10;
  // cycles per test including the three-cycle drain at its end
  localparam int LOGIC_CYC = 4 * 8 + 3;
  localparam int PERM_CYC = 3 * 4 + 3;
  localparam int BYP_CYC = 2 * 2 * `FPU_FWD_BUSES + 3;
  localparam int CMP_CYC = 11 + 12 + 3;
  localparam int EXC_CYC = 5 + 3 * 3;
  localparam int ILL_CYC = 5 + 3;
  localparam int WATCHDOG_NS = (RESET_CYC + LOGIC_CYC + PERM_CYC + BYP_CYC + CMP_CYC
                                + EXC_CYC + ILL_CYC + 50) * CLK_NS;

  localparam logic [63:0] D_ONE = 64'h3FF0_0000_0000_0000;
  localparam logic [63:0] D_TWO = 64'h4000_0000_0000_0000;
  localparam logic [63:0] D_MONE = 64'hBFF0_0000_0000_0000;
  localparam logic [63:0] D_MTWO = 64'hC000_0000_0000_0000;
  localparam logic [63:0] D_MZERO = 64'h8000_0000_0000_0000;
  localparam logic [63:0] D_INF = 64'h7FF0_0000_0000_0000;
  localparam logic [63:0] D_QNAN = 64'h7FF8_0000_0000_0000;
  localparam logic [63:0] D_SNAN = 64'h7FF0_0000_0000_0001;

  typedef struct packed {
    fpu_data_pkg::fpu_result_t res;
    logic                      excpt_en;
    logic [`FPU_EXC_W-1:0]     excpt_code;
  } expect_t;

  logic                      clk;
  logic                      rst;
  logic                      issue_en;
  fpu_op_pkg::fpu_opcode_e   opcode;
  fpu_op_pkg::opnd_src_t     src_a;
  fpu_op_pkg::opnd_src_t     src_b;
  fpu_data_pkg::fpu_word_u   rf_a;
  fpu_data_pkg::fpu_word_u   rf_b;
  fpu_data_pkg::fpu_word_u   fwd_bus [`FPU_FWD_BUSES];
  logic [31:0]               fpcsr;
  fpu_data_pkg::fpu_result_t res;
  logic                      excpt_en;
  logic [`FPU_EXC_W-1:0]     excpt_code;

  // bus values of this step and of the step before
  fpu_data_pkg::fpu_word_u cur_bus [`FPU_FWD_BUSES];
  fpu_data_pkg::fpu_word_u last_bus [`FPU_FWD_BUSES];
  logic [`FPU_FLAG_W-1:0]  csr_val;
  integer                  seed;
  // expected results delayed like the DUT pipeline
  expect_t                 exp_next;
  expect_t                 exp_s1;
  expect_t                 exp_s2;

  fpu_unit u_fpu_unit (
    .clk       (clk),
    .rst       (rst),
    .issue_en  (issue_en),
    .opcode    (opcode),
    .src_a     (src_a),
    .src_b     (src_b),
    .rf_a      (rf_a),
    .rf_b      (rf_b),
    .fwd_bus   (fwd_bus),
    .fpcsr     (fpcsr),
    .res       (res),
    .excpt_en  (excpt_en),
    .excpt_code(excpt_code)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [63:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic fpu_op_pkg::opnd_src_t src_of(input fpu_op_pkg::opnd_kind_e k,
                                                   input int idx);
    fpu_op_pkg::opnd_src_t s;
    s.kind = k;
    s.idx = idx[1:0];
    return s;
  endfunction

  function automatic fpu_data_pkg::fpu_word_u resolve(input fpu_op_pkg::opnd_src_t s,
                                                      input fpu_data_pkg::fpu_word_u rf);
    if (s.kind == fpu_op_pkg::SRC_BUS_NOW) return cur_bus[s.idx];
    if (s.kind == fpu_op_pkg::SRC_BUS_PREV) return last_bus[s.idx];
    return rf;
  endfunction

  // {nan, signaling}
  function automatic logic [1:0] nan_class(input logic exp_ones, input logic frac_nz,
                                           input logic quiet_bit);
    return {exp_ones & frac_nz, exp_ones & frac_nz & ~quiet_bit};
  endfunction

  // ieee order via signed keys where +0 and -0 both map to zero
  function automatic logic [3:0] order_flags(input logic nan, input logic sa,
                                             input logic [62:0] ma, input logic sb,
                                             input logic [62:0] mb);
    logic signed [64:0] ka;
    logic signed [64:0] kb;
    ka = sa ? -$signed({2'b00, ma}) : $signed({2'b00, ma});
    kb = sb ? -$signed({2'b00, mb}) : $signed({2'b00, mb});
    if (nan) return 4'b1000;
    return {1'b0, ka < kb, ka == kb, ka > kb};
  endfunction

  function automatic expect_t model(input logic en, input fpu_op_pkg::fpu_opcode_e op,
                                    input fpu_data_pkg::fpu_word_u a,
                                    input fpu_data_pkg::fpu_word_u b,
                                    input logic [`FPU_FLAG_W-1:0] csr);
    expect_t    e;
    logic       is_cmp;
    logic       pair;
    logic       ordered;
    logic [1:0] ca_h, cb_h, ca_l, cb_l, ca_d, cb_d;
    logic       any_nan, any_snan, invalid;
    e = '0;
    is_cmp = 1'b0;
    pair = 1'b0;
    ordered = 1'b0;
    if (!en) return e;
    case (op)
      fpu_op_pkg::OP_AND:   e.res.data = a & b;
      fpu_op_pkg::OP_OR:    e.res.data = a | b;
      fpu_op_pkg::OP_XOR:   e.res.data = a ^ b;
      fpu_op_pkg::OP_ANDN:  e.res.data = a & ~b;
      fpu_op_pkg::OP_SWAP:  e.res.data = {a.ps.lo, a.ps.hi};
      fpu_op_pkg::OP_DUPL:  e.res.data = {a.ps.lo, a.ps.lo};
      fpu_op_pkg::OP_MERGE: e.res.data = {b.ps.hi, a.ps.lo};
      fpu_op_pkg::OP_CMPD:  is_cmp = 1'b1;
      fpu_op_pkg::OP_CMPDO: {is_cmp, ordered} = 2'b11;
      fpu_op_pkg::OP_CMPS:  {is_cmp, pair} = 2'b11;
      fpu_op_pkg::OP_CMPSO: {is_cmp, pair, ordered} = 3'b111;
      default: return e;
    endcase
    e.res.valid = 1'b1;
    if (!is_cmp) return e;
    ca_h = nan_class(a.ps.hi.exp == '1, a.ps.hi.frac != '0, a.ps.hi.frac[22]);
    cb_h = nan_class(b.ps.hi.exp == '1, b.ps.hi.frac != '0, b.ps.hi.frac[22]);
    ca_l = nan_class(a.ps.lo.exp == '1, a.ps.lo.frac != '0, a.ps.lo.frac[22]);
    cb_l = nan_class(b.ps.lo.exp == '1, b.ps.lo.frac != '0, b.ps.lo.frac[22]);
    ca_d = nan_class(a.dbl.exp == '1, a.dbl.frac != '0, a.dbl.frac[51]);
    cb_d = nan_class(b.dbl.exp == '1, b.dbl.frac != '0, b.dbl.frac[51]);
    e.res.data = '0;
    if (pair) begin
      e.res.cmp.hi = order_flags(ca_h[1] | cb_h[1], a.ps.hi.sign, 63'(a.ps.hi[30:0]),
                                 b.ps.hi.sign, 63'(b.ps.hi[30:0]));
      e.res.cmp.lo = order_flags(ca_l[1] | cb_l[1], a.ps.lo.sign, 63'(a.ps.lo[30:0]),
                                 b.ps.lo.sign, 63'(b.ps.lo[30:0]));
      any_nan = ca_h[1] | cb_h[1] | ca_l[1] | cb_l[1];
      any_snan = ca_h[0] | cb_h[0] | ca_l[0] | cb_l[0];
    end else begin
      e.res.cmp.lo = order_flags(ca_d[1] | cb_d[1], a.dbl.sign, a[62:0], b.dbl.sign, b[62:0]);
      any_nan = ca_d[1] | cb_d[1];
      any_snan = ca_d[0] | cb_d[0];
    end
    // a compare can only raise invalid and that is code 1
    invalid = any_snan | (ordered & any_nan);
    e.excpt_en = invalid & csr[0];
    e.excpt_code = e.excpt_en ? `FPU_EXC_W'(1) : '0;
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
    $display("Testbench failed");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "%s", msg);
  endtask

  // one clock of stimulus with every input driven and fresh random bus values
  task automatic step(input logic en, input fpu_op_pkg::fpu_opcode_e op,
                      input fpu_op_pkg::opnd_src_t sa, input fpu_op_pkg::opnd_src_t sb,
                      input fpu_data_pkg::fpu_word_u ra, input fpu_data_pkg::fpu_word_u rb);
    fpu_data_pkg::fpu_word_u oa;
    fpu_data_pkg::fpu_word_u ob;
    @(posedge clk);
    for (int i = 0; i < `FPU_FWD_BUSES; i++) begin
      cur_bus[i] = rand_word();
    end
    oa = resolve(sa, ra);
    ob = resolve(sb, rb);
    issue_en <= en;
    opcode <= op;
    src_a <= sa;
    src_b <= sb;
    rf_a <= ra;
    rf_b <= rb;
    fpcsr <= {{(32 - `FPU_FLAG_W){1'b0}}, csr_val};
    for (int i = 0; i < `FPU_FWD_BUSES; i++) begin
      fwd_bus[i] <= cur_bus[i];
    end
    exp_next <= model(en, op, oa, ob, csr_val);
    for (int i = 0; i < `FPU_FWD_BUSES; i++) begin
      last_bus[i] = cur_bus[i];
    end
  endtask

  task automatic issue_rf(input fpu_op_pkg::fpu_opcode_e op, input logic [63:0] a,
                          input logic [63:0] b);
    step(1'b1, op, src_of(fpu_op_pkg::SRC_RF, 0), src_of(fpu_op_pkg::SRC_RF, 0), a, b);
  endtask

  // three idle cycles so every issued op has been checked
  task automatic drain();
    repeat (3) begin
      step(1'b0, fpu_op_pkg::OP_AND, src_of(fpu_op_pkg::SRC_RF, 0),
           src_of(fpu_op_pkg::SRC_RF, 0), '0, '0);
    end
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    assert (res.valid === 1'b0 && excpt_en === 1'b0)
      else stop_with_error("res.valid or excpt_en is not low right after reset");
  endtask

  // back to back with two ops in flight
  task automatic test_logic();
    fpu_op_pkg::fpu_opcode_e ops [4];
    ops = '{fpu_op_pkg::OP_AND, fpu_op_pkg::OP_OR, fpu_op_pkg::OP_XOR, fpu_op_pkg::OP_ANDN};
    foreach (ops[k]) begin
      repeat (8) issue_rf(ops[k], rand_word(), rand_word());
    end
    drain();
  endtask

  task automatic test_permute();
    fpu_op_pkg::fpu_opcode_e ops [3];
    ops = '{fpu_op_pkg::OP_SWAP, fpu_op_pkg::OP_DUPL, fpu_op_pkg::OP_MERGE};
    foreach (ops[k]) begin
      repeat (4) issue_rf(ops[k], rand_word(), rand_word());
    end
    drain();
  endtask

  // or with a zero register operand passes the bus value straight through
  task automatic test_bypass();
    fpu_op_pkg::opnd_kind_e kind;
    fpu_op_pkg::opnd_src_t  rf;
    rf = src_of(fpu_op_pkg::SRC_RF, 0);
    for (int k = 0; k < 2; k++) begin
      kind = (k == 0) ? fpu_op_pkg::SRC_BUS_NOW : fpu_op_pkg::SRC_BUS_PREV;
      for (int i = 0; i < `FPU_FWD_BUSES; i++) begin
        step(1'b1, fpu_op_pkg::OP_OR, src_of(kind, i), rf, '0, '0);
        step(1'b1, fpu_op_pkg::OP_OR, rf, src_of(kind, i), '0, '0);
      end
    end
    drain();
  endtask

  task automatic test_compare();
    issue_rf(fpu_op_pkg::OP_CMPD, D_ONE, D_TWO);
    issue_rf(fpu_op_pkg::OP_CMPD, D_TWO, D_ONE);
    issue_rf(fpu_op_pkg::OP_CMPD, D_MONE, D_ONE);
    issue_rf(fpu_op_pkg::OP_CMPD, D_MTWO, D_MONE);
    issue_rf(fpu_op_pkg::OP_CMPD, 64'h0, D_MZERO);
    issue_rf(fpu_op_pkg::OP_CMPD, D_QNAN, D_ONE);
    issue_rf(fpu_op_pkg::OP_CMPD, D_ONE, D_SNAN);
    issue_rf(fpu_op_pkg::OP_CMPD, D_INF, D_TWO);
    // paired singles given hi then lo
    issue_rf(fpu_op_pkg::OP_CMPS, 64'h3F800000_00000000, 64'h40000000_80000000);
    issue_rf(fpu_op_pkg::OP_CMPS, 64'h7FC00000_BF800000, 64'h3F800000_BF800000);
    issue_rf(fpu_op_pkg::OP_CMPS, 64'hBF800000_40000000, 64'hC0000000_3F800000);
    repeat (6) issue_rf(fpu_op_pkg::OP_CMPD, rand_word(), rand_word());
    repeat (6) issue_rf(fpu_op_pkg::OP_CMPS, rand_word(), rand_word());
    drain();
  endtask

  task automatic test_exception();
    csr_val = 5'b00001;
    issue_rf(fpu_op_pkg::OP_CMPDO, D_QNAN, D_ONE);
    issue_rf(fpu_op_pkg::OP_CMPD, D_QNAN, D_ONE);
    issue_rf(fpu_op_pkg::OP_CMPSO, 64'h3F800000_7FC00000, 64'h3F800000_3F800000);
    issue_rf(fpu_op_pkg::OP_CMPS, 64'h7F800001_00000000, 64'h0);
    drain();
    // invalid enable clear with the others set
    csr_val = 5'b11110;
    issue_rf(fpu_op_pkg::OP_CMPDO, D_QNAN, D_ONE);
    drain();
    csr_val = '0;
    drain();
  endtask

  task automatic test_illegal();
    issue_rf(fpu_op_pkg::fpu_opcode_e'(8'h00), rand_word(), rand_word());
    issue_rf(fpu_op_pkg::OP_XOR, rand_word(), rand_word());
    issue_rf(fpu_op_pkg::fpu_opcode_e'(8'hFF), rand_word(), rand_word());
    issue_rf(fpu_op_pkg::fpu_opcode_e'(8'h23), rand_word(), rand_word());
    step(1'b0, fpu_op_pkg::OP_CMPDO, src_of(fpu_op_pkg::SRC_RF, 0),
         src_of(fpu_op_pkg::SRC_RF, 0), D_QNAN, D_ONE);
    drain();
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp_s1 <= '0;
      exp_s2 <= '0;
    end else begin
      exp_s1 <= exp_next;
      exp_s2 <= exp_s1;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      assert (res.valid === exp_s2.res.valid)
        else report_mismatch("res.valid", 64'(res.valid), 64'(exp_s2.res.valid));
      if (exp_s2.res.valid) begin
        assert (res.data === exp_s2.res.data)
          else report_mismatch("res.data", res.data, exp_s2.res.data);
        assert (res.cmp === exp_s2.res.cmp)
          else report_mismatch("res.cmp", 64'(res.cmp), 64'(exp_s2.res.cmp));
      end
      assert (excpt_en === exp_s2.excpt_en)
        else report_mismatch("excpt_en", 64'(excpt_en), 64'(exp_s2.excpt_en));
      if (exp_s2.excpt_en) begin
        assert (excpt_code === exp_s2.excpt_code)
          else report_mismatch("excpt_code", 64'(excpt_code), 64'(exp_s2.excpt_code));
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

  initial begin
    seed = 32'h8118ef88;
    rst = 1'b1;
    issue_en = 1'b0;
    opcode = fpu_op_pkg::OP_AND;
    src_a = '0;
    src_b = '0;
    rf_a = '0;
    rf_b = '0;
    fpcsr = '0;
    csr_val = '0;
    exp_next = '0;
    for (int i = 0; i < `FPU_FWD_BUSES; i++) begin
      fwd_bus[i] = '0;
      cur_bus[i] = '0;
      last_bus[i] = '0;
    end
    repeat (RESET_CYC) @(posedge clk);
    rst <= 1'b0;
    check_reset_state();
    test_logic();
    test_permute();
    test_bypass();
    test_compare();
    test_exception();
    test_illegal();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
